// File: include/ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// ************************************************************
// widths fixed by the instruction set
`define INSTR_W        16
`define REG_SEL_W      4
`define ALU_MODE_W     4
`define CLASS_W        4
`define COND_W         3
`define SP_LOW_REG     4'd14      // low byte of the stack pointer pair

// ************************************************************
// instruction word fields
`define FLD_DEST       15:12
`define FLD_SRC        11:8
`define FLD_COND       15:13      // branch condition, overlaps dest
`define FLD_SUB        7:3
`define FLD_GRP        2:0
`define FLD_RI_OP      3:1
`define FLD_RR_OP      6:3
`define RI_FLAG_BIT    0

// opcode groups and sub-opcodes
`define GRP_IN         3'b010
`define GRP_OUT        3'b100
`define GRP_SUB        3'b000
`define RI_OP_LDI      3'b000     // load immediate, flags untouched
`define RI_OP_NONE     3'b111
`define SUB_ALU_FIRST  5'd1
`define SUB_ALU_LAST   5'd12
`define SUB_STORE      5'd13
`define SUB_LOAD       5'd16
`define SUB_JMP        5'd22
`define SUB_CALL       5'd23
`define SUB_RET        5'd24
`define SUB_PUS        5'd25
`define SUB_POS        5'd26
`define SUB_SSR        5'd27
`define SUB_CSR        5'd28
`define SUB_HLT        5'd29

// decoded classes
`define CLASS_NOP      4'd0
`define CLASS_ALU_IMM  4'd1
`define CLASS_IN       4'd2
`define CLASS_OUT      4'd3
`define CLASS_ALU_REG  4'd4
`define CLASS_PAIR_MEM 4'd5
`define CLASS_JMP      4'd6
`define CLASS_CALL     4'd7
`define CLASS_RET      4'd8
`define CLASS_PUS      4'd9
`define CLASS_POS      4'd10
`define CLASS_STAT_MASK 4'd11
`define CLASS_HLT      4'd12

// ALU modes
`define ALU_PASS_B     4'b0000
`define ALU_AND        4'b0001
`define ALU_OR         4'b0010
`define ALU_PASS_A     4'b1101

// ************************************************************
// datapath mux selects
`define REGSRC_ALU       2'b00
`define REGSRC_MEMIO     2'b10    // data memory / IO read bus
`define ALUA_STATUS      1'b0     // zero-extended status register
`define ALUA_REG         1'b1
`define ALUB_REG         2'b00
`define ALUB_MASK        2'b01    // 4-bit mask from the src field
`define ALUB_IMM         2'b10
`define DDATA_PC_HIGH    3'b000
`define DDATA_PC_LOW     3'b001
`define DDATA_ALU        3'b010
`define DADDR_PAIR       2'b00
`define DADDR_IMM        2'b01
`define DADDR_SP_PLUS1   2'b10
`define STATUS_ALU_FLAGS 2'b00
`define STATUS_ALU_OUT   2'b01
`define STATUS_MEM       2'b10
`define IADDR_PC_PLUS1   3'b000   // skips the inline address word
`define IADDR_PC         3'b001
`define IADDR_INSTR      3'b011
`define IADDR_RETURN     3'b101

`endif

// File: design/ctrl_pkg.sv
`include "ctrl_cfg.svh"

package ctrl_pkg;

    typedef logic [`INSTR_W-1:0]    instrWord_t;
    typedef logic [`REG_SEL_W-1:0]  regSel_t;
    typedef logic [`ALU_MODE_W-1:0] aluMode_t;
    typedef logic [`CLASS_W-1:0]    instrClass_t;
    typedef logic [`COND_W-1:0]     condCode_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } statusFlags_t;

    typedef struct packed {
        instrClass_t instrClass;
        regSel_t     destSel;
        regSel_t     srcSel;
        aluMode_t    aluOp;
        logic        isStore;
        logic        isLoadImm;
        logic        setMask;     // SSR, else CSR
    } decodedInstr_t;

    typedef struct packed {
        logic [1:0] src;
        regSel_t    outBSel;
        logic       writeEn;
        logic       incPair;
        logic       decPair;
    } regFileCtrl_t;

    typedef struct packed {
        logic       srcASel;
        logic [1:0] srcBSel;
        aluMode_t   mode;
    } aluCtrl_t;

    typedef struct packed {
        logic [1:0] srcSel;
        logic       flagEn;
    } statusCtrl_t;

    typedef struct packed {
        logic [2:0] dataSel;
        logic [1:0] addrSel;
        logic       writeEn;
        logic       readEn;
    } memIoCtrl_t;

    typedef struct packed {
        logic [2:0] addrSel;
        logic       readEn;
        logic       pcWriteEn;
    } fetchCtrl_t;

    typedef enum logic [2:0] {
        stepExec      = 3'b000,
        stepJmpAddr   = 3'b001,
        stepSecond    = 3'b010,    // second cycle of IN, load and RET
        stepCallHigh  = 3'b011,
        stepRetLast   = 3'b100,
        stepInitFetch = 3'b111
    } ctrlStep_t;

endpackage

// File: design/instrDecoder.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module instrDecoder (
    input  ctrl_pkg::instrWord_t    instr,
    input  ctrl_pkg::statusFlags_t  flags,
    output ctrl_pkg::decodedInstr_t decoded,
    output logic                    condTrue
);
    import ctrl_pkg::*;

    condCode_t cond;

    assign cond = instr[`FLD_COND];

    // ************************************************************
    // branch condition for JMP, CALL and RET
    always_comb begin
        case (cond)
            3'd1:    condTrue = flags.carry;
            3'd2:    condTrue = ~flags.carry;
            3'd3:    condTrue = flags.zero;
            3'd4:    condTrue = ~flags.zero;
            3'd5:    condTrue = flags.negative;
            3'd6:    condTrue = ~flags.negative;
            default: condTrue = 1'b1;            // 0 and 7 always
        endcase
    end

    // ************************************************************
    // class and field extraction
    always_comb begin
        decoded.instrClass = `CLASS_NOP;
        decoded.destSel    = instr[`FLD_DEST];
        decoded.srcSel     = instr[`FLD_SRC];    // also pair number and SSR/CSR mask
        decoded.aluOp      = `ALU_PASS_B;
        decoded.isStore    = (instr[`FLD_SUB] == `SUB_STORE);
        decoded.isLoadImm  = 1'b0;
        decoded.setMask    = (instr[`FLD_SUB] == `SUB_SSR);

        if (instr[`RI_FLAG_BIT] && instr[`FLD_RI_OP] != `RI_OP_NONE) begin
            decoded.instrClass = `CLASS_ALU_IMM;
            decoded.aluOp      = {1'b0, instr[`FLD_RI_OP]};
            decoded.isLoadImm  = (instr[`FLD_RI_OP] == `RI_OP_LDI);
        end else if (instr[`FLD_GRP] == `GRP_IN) begin
            decoded.instrClass = `CLASS_IN;
        end else if (instr[`FLD_GRP] == `GRP_OUT) begin
            decoded.instrClass = `CLASS_OUT;
        end else if (instr[`FLD_GRP] == `GRP_SUB) begin
            case (instr[`FLD_SUB]) inside
                [`SUB_ALU_FIRST:`SUB_ALU_LAST]: begin
                    decoded.instrClass = `CLASS_ALU_REG;
                    decoded.aluOp      = instr[`FLD_RR_OP];
                end
                `SUB_STORE, `SUB_LOAD: decoded.instrClass = `CLASS_PAIR_MEM;
                `SUB_JMP:              decoded.instrClass = `CLASS_JMP;
                `SUB_CALL:             decoded.instrClass = `CLASS_CALL;
                `SUB_RET:              decoded.instrClass = `CLASS_RET;
                `SUB_PUS:              decoded.instrClass = `CLASS_PUS;
                `SUB_POS:              decoded.instrClass = `CLASS_POS;
                `SUB_SSR, `SUB_CSR:    decoded.instrClass = `CLASS_STAT_MASK;
                `SUB_HLT:              decoded.instrClass = `CLASS_HLT;
                default:               decoded.instrClass = `CLASS_NOP;  // incl. old pair ops
            endcase
        end
    end

endmodule

// File: design/controlSequencer.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module controlSequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_pkg::decodedInstr_t decoded,
    input  logic                    condTrue,
    output ctrl_pkg::ctrlStep_t     step,
    output logic                    taken
);
    import ctrl_pkg::*;

    ctrlStep_t nextStep;

    // only the first cycle of an instruction looks at the condition
    assign taken = (step == stepExec) && condTrue;

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= stepInitFetch;
        end else begin
            step <= nextStep;
        end
    end

    // ************************************************************
    // next step; instr is held during stall steps so the class stays valid
    always_comb begin
        nextStep = stepExec;
        case (step)
            stepExec: begin
                case (decoded.instrClass)
                    `CLASS_IN:       nextStep = stepSecond;
                    `CLASS_PAIR_MEM: begin
                        if (!decoded.isStore) begin
                            nextStep = stepSecond;   // load waits for data
                        end
                    end
                    `CLASS_JMP:      nextStep = taken ? stepJmpAddr : stepExec;
                    `CLASS_CALL:     nextStep = taken ? stepCallHigh : stepExec;
                    `CLASS_RET:      nextStep = taken ? stepSecond : stepExec;
                    default:         nextStep = stepExec;
                endcase
            end
            stepSecond: begin
                if (decoded.instrClass == `CLASS_RET) begin
                    nextStep = stepRetLast;          // third pop cycle
                end
            end
            default: nextStep = stepExec;            // init, jmp addr, call high, ret last
        endcase
    end

endmodule

// File: design/regAluCtrl.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module regAluCtrl (
    input  ctrl_pkg::decodedInstr_t decoded,
    input  ctrl_pkg::ctrlStep_t     step,
    input  logic                    taken,
    output ctrl_pkg::regFileCtrl_t  regFile,
    output ctrl_pkg::aluCtrl_t      alu,
    output ctrl_pkg::statusCtrl_t   status
);
    import ctrl_pkg::*;

    regSel_t pairLow;
    logic    inSecond;

    assign pairLow  = {decoded.srcSel[`REG_SEL_W-1:1], 1'b0};  // even reg of pair
    assign inSecond = (step == stepSecond);

    always_comb begin
        regFile.src     = `REGSRC_ALU;
        regFile.outBSel = decoded.destSel;
        regFile.writeEn = 1'b0;
        regFile.incPair = 1'b0;
        regFile.decPair = 1'b0;
        alu.srcASel     = `ALUA_REG;
        alu.srcBSel     = `ALUB_REG;
        alu.mode        = `ALU_PASS_B;
        status.srcSel   = `STATUS_ALU_FLAGS;
        status.flagEn   = 1'b0;

        if (step == stepCallHigh) begin
            regFile.outBSel = `SP_LOW_REG;
            regFile.decPair = 1'b1;                      // room for the high byte
        end else if (step inside {stepExec, stepSecond, stepRetLast}) begin
            case (decoded.instrClass)
                `CLASS_ALU_IMM: begin
                    regFile.writeEn = 1'b1;
                    alu.srcBSel     = `ALUB_IMM;
                    alu.mode        = decoded.aluOp;
                    status.flagEn   = !decoded.isLoadImm;
                end
                `CLASS_ALU_REG: begin
                    regFile.outBSel = decoded.srcSel;
                    regFile.writeEn = 1'b1;
                    alu.mode        = decoded.aluOp;
                    status.flagEn   = 1'b1;
                end
                `CLASS_IN: begin
                    regFile.src     = `REGSRC_MEMIO;
                    regFile.writeEn = inSecond;          // data valid one cycle late
                end
                `CLASS_PAIR_MEM: begin
                    regFile.src     = `REGSRC_MEMIO;
                    regFile.outBSel = pairLow;
                    regFile.writeEn = inSecond && !decoded.isStore;
                    alu.mode        = `ALU_PASS_A;       // store data from reg A
                end
                `CLASS_CALL: begin
                    regFile.outBSel = `SP_LOW_REG;
                    regFile.decPair = taken;             // low byte push
                end
                `CLASS_RET: begin
                    regFile.outBSel = `SP_LOW_REG;
                    regFile.incPair = taken || inSecond;
                end
                `CLASS_PUS: begin
                    regFile.outBSel = `SP_LOW_REG;
                    regFile.decPair = 1'b1;
                    alu.srcASel     = `ALUA_STATUS;
                    alu.mode        = `ALU_PASS_A;
                end
                `CLASS_POS: begin
                    regFile.outBSel = `SP_LOW_REG;
                    regFile.incPair = 1'b1;
                    status.srcSel   = `STATUS_MEM;
                    status.flagEn   = 1'b1;
                end
                `CLASS_STAT_MASK: begin
                    alu.srcASel     = `ALUA_STATUS;
                    alu.srcBSel     = `ALUB_MASK;
                    alu.mode        = decoded.setMask ? `ALU_OR : `ALU_AND;
                    status.srcSel   = `STATUS_ALU_OUT;
                    status.flagEn   = 1'b1;
                end
                default: begin
                    regFile.writeEn = 1'b0;              // OUT, JMP, HLT, NOP
                end
            endcase
        end
    end

endmodule

// File: design/memIoCtrl.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module memIoCtrl (
    input  ctrl_pkg::decodedInstr_t decoded,
    input  ctrl_pkg::ctrlStep_t     step,
    input  logic                    taken,
    output ctrl_pkg::memIoCtrl_t    memIo
);
    import ctrl_pkg::*;

    always_comb begin
        memIo.dataSel = `DDATA_ALU;
        memIo.addrSel = `DADDR_PAIR;     // pair or SP, whichever reg B reads
        memIo.writeEn = 1'b0;
        memIo.readEn  = 1'b0;

        if (step == stepCallHigh) begin
            memIo.dataSel = `DDATA_PC_HIGH;
            memIo.writeEn = 1'b1;
        end else if (step inside {stepExec, stepSecond, stepRetLast}) begin
            case (decoded.instrClass)
                `CLASS_IN: begin
                    memIo.addrSel = `DADDR_IMM;
                    memIo.readEn  = 1'b1;
                end
                `CLASS_OUT: begin
                    memIo.addrSel = `DADDR_IMM;
                    memIo.writeEn = 1'b1;
                end
                `CLASS_PAIR_MEM: begin
                    memIo.writeEn = decoded.isStore;
                    memIo.readEn  = !decoded.isStore;
                end
                `CLASS_CALL: begin
                    memIo.dataSel = `DDATA_PC_LOW;
                    memIo.writeEn = taken;
                end
                `CLASS_RET: begin
                    memIo.addrSel = `DADDR_SP_PLUS1;  // SP points below the top byte
                    memIo.readEn  = 1'b1;
                end
                `CLASS_PUS: memIo.writeEn = 1'b1;
                `CLASS_POS: memIo.readEn  = 1'b1;
                default:    memIo.readEn  = 1'b0;
            endcase
        end
    end

endmodule

// File: design/fetchCtrl.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module fetchCtrl (
    input  ctrl_pkg::decodedInstr_t decoded,
    input  ctrl_pkg::ctrlStep_t     step,
    input  logic                    taken,
    output ctrl_pkg::fetchCtrl_t    fetch
);
    import ctrl_pkg::*;

    logic isRet;

    assign isRet = (decoded.instrClass == `CLASS_RET);

    always_comb begin
        fetch.addrSel   = `IADDR_PC;
        fetch.readEn    = 1'b1;
        fetch.pcWriteEn = 1'b1;

        case (step)
            stepExec: begin
                case (decoded.instrClass)
                    `CLASS_IN, `CLASS_HLT: begin
                        fetch.readEn    = 1'b0;
                        fetch.pcWriteEn = 1'b0;
                    end
                    `CLASS_PAIR_MEM: begin
                        fetch.readEn    = decoded.isStore;
                        fetch.pcWriteEn = decoded.isStore;
                    end
                    `CLASS_JMP: begin
                        fetch.addrSel = taken ? `IADDR_PC : `IADDR_PC_PLUS1;
                    end
                    `CLASS_CALL: begin
                        // taken: read the target word, hold PC for the high byte
                        fetch.addrSel   = taken ? `IADDR_PC : `IADDR_PC_PLUS1;
                        fetch.pcWriteEn = !taken;
                    end
                    `CLASS_RET: begin
                        fetch.addrSel   = taken ? `IADDR_RETURN : `IADDR_PC;
                        fetch.readEn    = !taken;
                        fetch.pcWriteEn = !taken;
                    end
                    default: fetch.addrSel = `IADDR_PC;
                endcase
            end
            stepSecond: begin
                if (isRet) begin
                    fetch.addrSel   = `IADDR_RETURN;
                    fetch.readEn    = 1'b0;
                    fetch.pcWriteEn = 1'b0;
                end
            end
            stepRetLast:               fetch.addrSel = `IADDR_RETURN;
            stepJmpAddr, stepCallHigh: fetch.addrSel = `IADDR_INSTR;  // word is the target
            default:                   fetch.addrSel = `IADDR_PC;     // initial fetch
        endcase
    end

endmodule

// File: design/cpuControl.sv
`timescale 1ns/1ns

module cpuControl (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_pkg::instrWord_t   instr,
    input  ctrl_pkg::statusFlags_t flags,
    output ctrl_pkg::regFileCtrl_t regFile,
    output ctrl_pkg::aluCtrl_t     alu,
    output ctrl_pkg::statusCtrl_t  status,
    output ctrl_pkg::memIoCtrl_t   memIo,
    output ctrl_pkg::fetchCtrl_t   fetch
);
    import ctrl_pkg::*;

    decodedInstr_t decoded;
    logic          condTrue;
    ctrlStep_t     step;
    logic          taken;

    instrDecoder u_instrDecoder (
        .instr    (instr),
        .flags    (flags),
        .decoded  (decoded),
        .condTrue (condTrue)
    );

    controlSequencer u_controlSequencer (
        .clk      (clk),
        .rst      (rst),
        .decoded  (decoded),
        .condTrue (condTrue),
        .step     (step),
        .taken    (taken)
    );

    regAluCtrl u_regAluCtrl (
        .decoded (decoded),
        .step    (step),
        .taken   (taken),
        .regFile (regFile),
        .alu     (alu),
        .status  (status)
    );

    memIoCtrl u_memIoCtrl (
        .decoded (decoded),
        .step    (step),
        .taken   (taken),
        .memIo   (memIo)
    );

    fetchCtrl u_fetchCtrl (
        .decoded (decoded),
        .step    (step),
        .taken   (taken),
        .fetch   (fetch)
    );

endmodule

// File: dv/controlChecker.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module controlChecker (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_pkg::instrWord_t   instr,
    input  ctrl_pkg::statusFlags_t flags,
    input  ctrl_pkg::regFileCtrl_t regFile,
    input  ctrl_pkg::aluCtrl_t     alu,
    input  ctrl_pkg::statusCtrl_t  status,
    input  ctrl_pkg::memIoCtrl_t   memIo,
    input  ctrl_pkg::fetchCtrl_t   fetch,
    output int                     errorCount,
    output logic                   allSeen
);
    import ctrl_pkg::*;

    string        testName [6] = '{"reset", "alu", "inLoadOutStore", "jmpCall", "ret",
                                   "stackStatusHlt"};
    int           checks [6];
    int           errors [6];
    logic [5:0]   seen;
    ctrlStep_t    mStep;
    ctrlStep_t    mNext;
    instrClass_t  cls;
    logic         tk;
    logic         isSecond;
    logic         store;
    int           beh;
    regFileCtrl_t eReg;
    aluCtrl_t     eAlu;
    statusCtrl_t  eStat;
    memIoCtrl_t   eMem;
    fetchCtrl_t   eFetch;

    assign allSeen = &seen;

    initial begin
        mStep      = stepInitFetch;
        seen       = '0;
        errorCount = 0;
        for (int i = 0; i < 6; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
    end

    // condition codes 0 and 7 mean always
    function automatic logic condHolds(input logic [2:0] c, input statusFlags_t f);
        case (c)
            3'd1:    return f.carry;
            3'd2:    return !f.carry;
            3'd3:    return f.zero;
            3'd4:    return !f.zero;
            3'd5:    return f.negative;
            3'd6:    return !f.negative;
            default: return 1'b1;
        endcase
    endfunction

    function automatic instrClass_t classOf(input instrWord_t w);
        if (w[0] && w[3:1] != 3'b111) return `CLASS_ALU_IMM;
        if (w[2:0] == `GRP_IN) return `CLASS_IN;
        if (w[2:0] == `GRP_OUT) return `CLASS_OUT;
        if (w[2:0] != `GRP_SUB) return `CLASS_NOP;
        if (w[7:3] >= 5'd1 && w[7:3] <= 5'd12) return `CLASS_ALU_REG;
        case (w[7:3])
            5'd13, 5'd16: return `CLASS_PAIR_MEM;
            5'd22:        return `CLASS_JMP;
            5'd23:        return `CLASS_CALL;
            5'd24:        return `CLASS_RET;
            5'd25:        return `CLASS_PUS;
            5'd26:        return `CLASS_POS;
            5'd27, 5'd28: return `CLASS_STAT_MASK;
            5'd29:        return `CLASS_HLT;
            default:      return `CLASS_NOP;
        endcase
    endfunction

    task automatic compareField(input int b, input string what,
                                input logic [15:0] expVal, input logic [15:0] actVal);
        checks[b]++;
        if (expVal !== actVal) begin
            errors[b]++;
            errorCount++;
            $display("mismatch %s %s expected %h actual %h", testName[b], what, expVal, actVal);
        end
    endtask

    task automatic printReport();
        int total;
        total = 0;
        for (int i = 0; i < 6; i++) begin
            total += checks[i];
            $display("%s: %0d checks, %0d errors", testName[i], checks[i], errors[i]);
        end
        $display("checks %0d, errors %0d", total, errorCount);
    endtask

    // ************************************************************
    // expected outputs from step, class and condition
    always_comb begin
        cls      = classOf(instr);
        store    = (instr[7:3] == 5'd13);
        isSecond = (mStep == stepSecond);
        tk       = (mStep == stepExec) && condHolds(instr[15:13], flags);
        eReg     = '{src: `REGSRC_ALU, outBSel: instr[15:12], default: 1'b0};
        eAlu     = '{srcASel: `ALUA_REG, srcBSel: `ALUB_REG, mode: `ALU_PASS_B};
        eStat    = '{srcSel: `STATUS_ALU_FLAGS, flagEn: 1'b0};
        eMem     = '{dataSel: `DDATA_ALU, addrSel: `DADDR_PAIR, writeEn: 1'b0, readEn: 1'b0};
        eFetch   = '{addrSel: `IADDR_PC, readEn: 1'b1, pcWriteEn: 1'b1};
        if (mStep == stepCallHigh) begin
            eReg.outBSel   = `SP_LOW_REG;
            eReg.decPair   = 1'b1;
            eMem.dataSel   = `DDATA_PC_HIGH;
            eMem.writeEn   = 1'b1;
            eFetch.addrSel = `IADDR_INSTR;
        end else if (mStep == stepJmpAddr) begin
            eFetch.addrSel = `IADDR_INSTR;
        end else if (mStep != stepInitFetch) begin
            case (cls)
                `CLASS_ALU_IMM: begin
                    eReg.writeEn  = 1'b1;
                    eAlu.srcBSel  = `ALUB_IMM;
                    eAlu.mode     = {1'b0, instr[3:1]};
                    eStat.flagEn  = (instr[3:1] != 3'b000);  // load-immediate keeps flags
                end
                `CLASS_ALU_REG: begin
                    eReg.outBSel  = instr[11:8];
                    eReg.writeEn  = 1'b1;
                    eAlu.mode     = instr[6:3];
                    eStat.flagEn  = 1'b1;
                end
                `CLASS_IN: begin
                    eReg.src      = `REGSRC_MEMIO;
                    eReg.writeEn  = isSecond;
                    eMem.addrSel  = `DADDR_IMM;
                    eMem.readEn   = 1'b1;
                    if (mStep == stepExec) begin
                        eFetch.readEn    = 1'b0;
                        eFetch.pcWriteEn = 1'b0;
                    end
                end
                `CLASS_OUT: begin
                    eMem.addrSel  = `DADDR_IMM;
                    eMem.writeEn  = 1'b1;
                end
                `CLASS_PAIR_MEM: begin
                    eReg.src      = `REGSRC_MEMIO;
                    eReg.outBSel  = {instr[11:9], 1'b0};
                    eReg.writeEn  = isSecond && !store;
                    eAlu.mode     = `ALU_PASS_A;
                    eMem.writeEn  = store;
                    eMem.readEn   = !store;
                    if (mStep == stepExec) begin
                        eFetch.readEn    = store;
                        eFetch.pcWriteEn = store;
                    end
                end
                `CLASS_JMP: eFetch.addrSel = tk ? `IADDR_PC : `IADDR_PC_PLUS1;
                `CLASS_CALL: begin
                    eReg.outBSel     = `SP_LOW_REG;
                    eReg.decPair     = tk;
                    eMem.dataSel     = `DDATA_PC_LOW;
                    eMem.writeEn     = tk;
                    eFetch.addrSel   = tk ? `IADDR_PC : `IADDR_PC_PLUS1;
                    eFetch.pcWriteEn = !tk;
                end
                `CLASS_RET: begin
                    eReg.outBSel  = `SP_LOW_REG;
                    eReg.incPair  = tk || isSecond;
                    eMem.addrSel  = `DADDR_SP_PLUS1;
                    eMem.readEn   = 1'b1;
                    if (mStep == stepExec) begin
                        eFetch.addrSel   = tk ? `IADDR_RETURN : `IADDR_PC;
                        eFetch.readEn    = !tk;
                        eFetch.pcWriteEn = !tk;
                    end else begin
                        eFetch.addrSel   = `IADDR_RETURN;
                        eFetch.readEn    = !isSecond;
                        eFetch.pcWriteEn = !isSecond;
                    end
                end
                `CLASS_PUS: begin
                    eReg.outBSel  = `SP_LOW_REG;
                    eReg.decPair  = 1'b1;
                    eAlu.srcASel  = `ALUA_STATUS;
                    eAlu.mode     = `ALU_PASS_A;
                    eMem.writeEn  = 1'b1;
                end
                `CLASS_POS: begin
                    eReg.outBSel  = `SP_LOW_REG;
                    eReg.incPair  = 1'b1;
                    eStat.srcSel  = `STATUS_MEM;
                    eStat.flagEn  = 1'b1;
                    eMem.readEn   = 1'b1;
                end
                `CLASS_STAT_MASK: begin
                    eAlu.srcASel  = `ALUA_STATUS;
                    eAlu.srcBSel  = `ALUB_MASK;
                    eAlu.mode     = (instr[7:3] == 5'd27) ? `ALU_OR : `ALU_AND;
                    eStat.srcSel  = `STATUS_ALU_OUT;
                    eStat.flagEn  = 1'b1;
                end
                `CLASS_HLT: begin
                    eFetch.readEn    = 1'b0;
                    eFetch.pcWriteEn = 1'b0;
                end
                default: eReg.writeEn = 1'b0;
            endcase
        end
    end

    // ************************************************************
    // step model
    always_comb begin
        mNext = stepExec;
        if (mStep == stepExec) begin
            if (cls == `CLASS_IN || (cls == `CLASS_PAIR_MEM && !store)) mNext = stepSecond;
            if (cls == `CLASS_JMP && tk) mNext = stepJmpAddr;
            if (cls == `CLASS_CALL && tk) mNext = stepCallHigh;
            if (cls == `CLASS_RET && tk) mNext = stepSecond;
        end else if (mStep == stepSecond && cls == `CLASS_RET) begin
            mNext = stepRetLast;
        end
    end

    always_comb begin
        case (cls)
            `CLASS_ALU_IMM, `CLASS_ALU_REG:          beh = 1;
            `CLASS_IN, `CLASS_OUT, `CLASS_PAIR_MEM:  beh = 2;
            `CLASS_JMP, `CLASS_CALL:                 beh = 3;
            `CLASS_RET:                              beh = 4;
            default:                                 beh = 5;
        endcase
        if (mStep inside {stepJmpAddr, stepCallHigh}) beh = 3;  // word on instr is the target
        if (mStep == stepInitFetch) beh = 0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            compareField(beh, "regFile", 16'(eReg), 16'(regFile));
            compareField(beh, "alu", 16'(eAlu), 16'(alu));
            compareField(beh, "status", 16'(eStat), 16'(status));
            compareField(beh, "memIo", 16'(eMem), 16'(memIo));
            compareField(beh, "fetch", 16'(eFetch), 16'(fetch));
            if (beh == 0 || beh == 1 || (beh == 2 && isSecond)) seen[beh] = 1'b1;
            if (beh == 3 && mStep inside {stepJmpAddr, stepCallHigh}) seen[3] = 1'b1;
            if (beh == 4 && mStep == stepRetLast) seen[4] = 1'b1;
            if (beh == 5 && cls == `CLASS_HLT) seen[5] = 1'b1;
        end
        mStep <= rst ? stepInitFetch : mNext;
    end

endmodule

// File: dv/tbCpuControl.sv
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module tbCpuControl;
    import ctrl_pkg::*;

    logic         clk;
    logic         rst;
    instrWord_t   instr;
    statusFlags_t flags;
    regFileCtrl_t regFile;
    aluCtrl_t     alu;
    statusCtrl_t  status;
    memIoCtrl_t   memIo;
    fetchCtrl_t   fetch;
    int           errorCount;
    logic         allSeen;
    logic [31:0]  lfsr;
    logic         fetchedLast;
    logic         isHalt;
    int           haltCycles;
    int           cyc;

    cpuControl u_cpuControl (
        .clk(clk), .rst(rst), .instr(instr), .flags(flags),
        .regFile(regFile), .alu(alu), .status(status), .memIo(memIo), .fetch(fetch)
    );

    controlChecker u_checker (
        .clk(clk), .rst(rst), .instr(instr), .flags(flags),
        .regFile(regFile), .alu(alu), .status(status), .memIo(memIo), .fetch(fetch),
        .errorCount(errorCount), .allSeen(allSeen)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction memory delivers a new word only after a fetch
    always @(posedge clk) fetchedLast <= fetch.readEn;

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic newWord();
        logic [15:0] sel;
        logic [15:0] hi;
        logic [15:0] lo;
        logic [15:0] f;
        sel = randBits(4);
        hi  = randBits(8);
        lo  = randBits(8);
        f   = randBits(3);
        isHalt = 1'b0;
        case (sel[3:0])
            4'd0, 4'd1: lo[0] = 1'b1;                    // ALU immediate or filler
            4'd2:  lo[2:0] = `GRP_IN;
            4'd3:  lo[2:0] = `GRP_OUT;
            4'd4:  lo = {5'(1 + lo[7:3] % 12), 3'b000};
            4'd5:  lo = {`SUB_STORE, 3'b000};
            4'd6:  lo = {`SUB_LOAD, 3'b000};
            4'd7:  lo = {`SUB_JMP, 3'b000};
            4'd8:  lo = {`SUB_CALL, 3'b000};
            4'd9:  lo = {`SUB_RET, 3'b000};
            4'd10: lo = {`SUB_PUS, 3'b000};
            4'd11: lo = {`SUB_POS, 3'b000};
            4'd12: lo = {lo[0] ? `SUB_SSR : `SUB_CSR, 3'b000};
            4'd13: begin
                lo     = {`SUB_HLT, 3'b000};
                isHalt = 1'b1;
            end
            default: lo = lo;                            // random filler
        endcase
        instr = {hi[7:0], lo[7:0]};
        flags = f[2:0];
    endtask

    initial begin
        lfsr       = 32'hd46bb0fe;
        rst        = 1'b1;
        instr      = '0;
        flags      = '0;
        isHalt     = 1'b0;
        haltCycles = 0;
        cyc        = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        while ((cyc < 4000 || !allSeen) && cyc < 40000) begin
            @(negedge clk);
            cyc++;
            if (haltCycles >= 4) begin
                rst        = 1'b1;                       // leave HLT through reset
                haltCycles = 0;
                isHalt     = 1'b0;
            end else begin
                rst = 1'b0;
                if (fetchedLast) begin
                    newWord();
                end else if (isHalt) begin
                    haltCycles++;
                end
            end
        end
        u_checker.printReport();
        if (!allSeen) begin
            $display("timed out waiting for every behavior to occur");
            $display("Some tests failed");
        end else if (errorCount != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
design/ctrl_pkg.sv
design/instrDecoder.sv
design/controlSequencer.sv
design/regAluCtrl.sv
design/memIoCtrl.sv
design/fetchCtrl.sv
design/cpuControl.sv
dv/controlChecker.sv
dv/tbCpuControl.sv

// File: Bender.yml
package:
  name: cpu_control

sources:
  - include_dirs:
      - include
    files:
      - design/ctrl_pkg.sv
      - design/instrDecoder.sv
      - design/controlSequencer.sv
      - design/regAluCtrl.sv
      - design/memIoCtrl.sv
      - design/fetchCtrl.sv
      - design/cpuControl.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/controlChecker.sv
      - dv/tbCpuControl.sv
